//--- hw/frame_ram.sv
module frame_ram #(
	parameter type word_t = msg_pkg::ram_word_t
) (
	input  logic           clk,

	input  msg_pkg::addr_t wr_addr,
	input  word_t          wr_data,
	input  logic           wr_en,

	input  msg_pkg::addr_t rd_addr,
	output word_t          rd_data
);
	import msg_pkg::*;

	word_t mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign rd_data = mem[rd_addr]; // async read

endmodule

//--- hw/frame_reader.sv
module frame_reader (
	input  logic               clk,
	input  logic               rst,

	input  msg_pkg::ram_word_t out_word,
	input  logic               out_empty,
	input  logic               out_frame_ready,
	output logic               out_pop,

	output msg_pkg::byte_t     tx_data,
	output logic               tx_valid,
	output logic               tx_first,
	output logic               tx_last,
	input  logic               tx_hold
);
	import msg_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_send
	} state_t;

	state_t state;
	state_t next_state;

	logic next_sof;
	logic frame_waiting;
	logic taken;

	assign next_sof = out_word[data_w];
	assign frame_waiting = out_frame_ready && !out_empty && next_sof;

	assign tx_valid = (state == st_send);

	// tail already points past the byte on tx_data
	assign tx_last = tx_valid && (out_empty || next_sof);

	assign taken = tx_valid && !tx_hold;

	assign out_pop = (state == st_load) || (taken && !tx_last);

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (frame_waiting) begin
					next_state = st_load;
				end
			end

			st_load: begin
				next_state = st_send;
			end

			st_send: begin
				if (taken && tx_last) begin
					next_state = st_idle;
				end
			end

			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			tx_first <= 1'b0;
		end else begin
			state <= next_state;
			if (out_pop) begin
				tx_first <= next_sof; // only set on the frame's first word
			end else if (taken && tx_last) begin
				tx_first <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_pop) begin
			tx_data <= out_word[data_w-1:0];
		end
	end

	// tx_last comes from the buffer side so this also checks the FIFO contents
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		tx_valid && tx_hold |=>
		tx_valid && $stable(tx_data) && $stable(tx_first) && $stable(tx_last))
		else $error("tx outputs moved during hold");

endmodule

//--- hw/message_buffer.sv
module message_buffer (
	input  logic           clk,
	input  logic           rst,

	input  msg_pkg::byte_t in_data,
	input  logic           in_data_latch,
	input  logic           in_frame_valid,
	input  logic           populate_frame_length,
	output logic           in_data_overflow,

	output msg_pkg::byte_t tx_data,
	output logic           tx_valid,
	output logic           tx_first,
	output logic           tx_last,
	input  logic           tx_hold
);
	import msg_pkg::*;

	ram_word_t out_word;
	logic out_empty;
	logic out_frame_ready;
	logic out_pop;

	message_fifo u_fifo (
		.clk                   (clk),
		.rst                   (rst),
		.in_data               (in_data),
		.in_data_latch         (in_data_latch),
		.in_frame_valid        (in_frame_valid),
		.populate_frame_length (populate_frame_length),
		.in_data_overflow      (in_data_overflow),
		.out_word              (out_word),
		.out_empty             (out_empty),
		.out_frame_ready       (out_frame_ready),
		.out_pop               (out_pop)
	);

	frame_reader u_reader (
		.clk             (clk),
		.rst             (rst),
		.out_word        (out_word),
		.out_empty       (out_empty),
		.out_frame_ready (out_frame_ready),
		.out_pop         (out_pop),
		.tx_data         (tx_data),
		.tx_valid        (tx_valid),
		.tx_first        (tx_first),
		.tx_last         (tx_last),
		.tx_hold         (tx_hold)
	);

endmodule

//--- hw/message_fifo.sv
module message_fifo (
	input  logic               clk,
	input  logic               rst,

	input  msg_pkg::byte_t     in_data,
	input  logic               in_data_latch,
	input  logic               in_frame_valid,
	input  logic               populate_frame_length,
	output logic               in_data_overflow,

	output msg_pkg::ram_word_t out_word,
	output logic               out_empty,
	output logic               out_frame_ready,
	input  logic               out_pop
);
	import msg_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_record,
		st_patch_hi,
		st_patch_lo
	} state_t;

	state_t state;
	state_t next_state;

	addr_t head;
	addr_t tail;
	addr_t frame_start;
	len_t byte_cnt;
	logic [depth_log2:0] frame_cnt; // up to depth-1 one-byte frames
	logic last_frame_valid;
	logic full;

	logic start_frame;
	logic push_byte;
	logic drop_frame;
	logic frame_done;
	logic patch_hi;
	logic patch_lo;
	logic frame_dec;

	addr_t wr_addr;
	ram_word_t wr_word;
	logic wr_en;

	assign full = (head == addr_t'(tail - 1'b1));
	assign in_data_overflow = full;
	assign out_empty = (tail == head);
	assign out_frame_ready = (frame_cnt != '0);
	assign frame_dec = out_pop && out_word[data_w]; // reader took a frame start

	always_comb begin
		next_state = state;
		start_frame = 1'b0;
		push_byte = 1'b0;
		drop_frame = 1'b0;
		frame_done = 1'b0;
		patch_hi = 1'b0;
		patch_lo = 1'b0;

		case (state)
			st_idle: begin
				// no room means the whole frame is skipped
				if (in_frame_valid && !last_frame_valid && !full) begin
					start_frame = 1'b1;
					next_state = st_record;
				end
			end

			st_record: begin
				if (!in_frame_valid) begin
					if (populate_frame_length && byte_cnt >= len_t'(min_patch_len)) begin
						next_state = st_patch_hi;
					end else begin
						frame_done = 1'b1;
						next_state = st_idle;
					end
				end else if (full) begin
					drop_frame = 1'b1; // rest ignored until next rising edge
					next_state = st_idle;
				end else if (in_data_latch) begin
					push_byte = 1'b1;
				end
			end

			st_patch_hi: begin
				patch_hi = 1'b1;
				next_state = st_patch_lo;
			end

			st_patch_lo: begin
				patch_lo = 1'b1;
				frame_done = 1'b1; // count only once the patch is in
				next_state = st_idle;
			end

			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_comb begin
		wr_addr = head;
		wr_word = {start_frame, in_data};
		if (patch_hi) begin
			wr_addr = frame_start + addr_t'(len_offset);
			wr_word = {1'b0, byte_cnt[len_w-1 -: data_w]};
		end else if (patch_lo) begin
			wr_addr = frame_start + addr_t'(len_offset + 1);
			wr_word = {1'b0, byte_cnt[data_w-1:0]};
		end
	end

	assign wr_en = start_frame || push_byte || patch_hi || patch_lo;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			head <= '0;
			tail <= '0;
			frame_cnt <= '0;
			last_frame_valid <= 1'b0;
		end else begin
			state <= next_state;
			last_frame_valid <= in_frame_valid;

			if (start_frame || push_byte) begin
				head <= head + 1'b1;
			end else if (drop_frame) begin
				head <= frame_start;
			end

			if (out_pop) begin
				tail <= tail + 1'b1;
			end

			case ({frame_done, frame_dec})
				2'b10: begin
					frame_cnt <= frame_cnt + 1'b1;
				end
				2'b01: begin
					frame_cnt <= frame_cnt - 1'b1;
				end
				default: begin
					frame_cnt <= frame_cnt;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_frame) begin
			frame_start <= head;
			byte_cnt <= len_t'(1); // byte 0 comes with the edge
		end else if (push_byte) begin
			byte_cnt <= byte_cnt + 1'b1;
		end
	end

	frame_ram #(
		.word_t (ram_word_t)
	) u_ram (
		.clk     (clk),
		.wr_addr (wr_addr),
		.wr_data (wr_word),
		.wr_en   (wr_en),
		.rd_addr (tail),
		.rd_data (out_word)
	);

	// a full buffer either holds head or falls back to the frame start
	a_no_advance_full: assert property (@(posedge clk) disable iff (rst)
		full |=> (head == $past(head)) || (head == $past(frame_start)))
		else $error("head advanced while full");

	a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
		out_pop |-> !out_empty)
		else $error("pop from empty buffer");

	a_cnt_no_wrap: assert property (@(posedge clk) disable iff (rst)
		!(frame_dec && !frame_done && frame_cnt == '0) &&
		!(frame_done && !frame_dec && &frame_cnt))
		else $error("frame count wrapped");

endmodule

//--- hw/msg_pkg.sv
package msg_pkg;

	localparam int depth_log2 = 8;
	localparam int depth = 1 << depth_log2;

	localparam int data_w = 8;
	localparam int len_w = 16;

	localparam int len_offset = 2; // high length byte, low one follows
	localparam int min_patch_len = 4;

	typedef logic [depth_log2-1:0] addr_t;
	typedef logic [data_w-1:0] byte_t;
	typedef logic [len_w-1:0] len_t;

	// top bit marks the first byte of a frame
	typedef logic [data_w:0] ram_word_t;

endpackage

//--- project.f
hw/msg_pkg.sv
hw/frame_ram.sv
hw/message_fifo.sv
hw/frame_reader.sv
hw/message_buffer.sv
sim/tb_message_buffer.sv

//--- sim/tb_message_buffer.sv
module tb_message_buffer;
	timeunit 1ns;
	timeprecision 1ps;
	import msg_pkg::*;

	// 5 tests at roughly 60, 120, 600, 500 and 300 cycles, plus margin
	localparam int cycle_limit = 60 + 120 + 600 + 500 + 300 + 400;

	logic clk = 1'b0;
	logic rst;
	byte_t in_data;
	logic in_data_latch;
	logic in_frame_valid;
	logic populate_frame_length;
	logic in_data_overflow;
	byte_t tx_data;
	logic tx_valid;
	logic tx_first;
	logic tx_last;
	logic tx_hold;

	byte_t frame_buf [300];
	byte_t exp_data [$];
	bit exp_first [$];
	bit exp_last [$];
	byte_t rx_data [$];
	bit rx_first [$];
	bit rx_last [$];

	int cycles = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit hold_random = 1'b0;
	bit hold_force = 1'b0;
	bit seen_overflow = 1'b0;

	message_buffer uut (
		.clk                   (clk),
		.rst                   (rst),
		.in_data               (in_data),
		.in_data_latch         (in_data_latch),
		.in_frame_valid        (in_frame_valid),
		.populate_frame_length (populate_frame_length),
		.in_data_overflow      (in_data_overflow),
		.tx_data               (tx_data),
		.tx_valid              (tx_valid),
		.tx_first              (tx_first),
		.tx_last               (tx_last),
		.tx_hold               (tx_hold)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (hold_force) begin
			tx_hold <= 1'b1;
		end else if (hold_random) begin
			tx_hold <= ($urandom % 3) == 0; // held about a third of the time
		end else begin
			tx_hold <= 1'b0;
		end
	end

	// byte is taken on the next edge when valid and not held
	always @(negedge clk) begin
		if (!rst && tx_valid && !tx_hold) begin
			rx_data.push_back(tx_data);
			rx_first.push_back(tx_first);
			rx_last.push_back(tx_last);
		end
		if (!rst && in_data_overflow) begin
			seen_overflow = 1'b1;
		end
	end

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit expected, input bit actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic fill_payload(input int len);
		for (int i = 0; i < len; i++) begin
			frame_buf[i] = byte_t'($urandom);
		end
	endtask

	// expected frame as delivered, length field big-endian at len_offset
	task automatic expect_frame(input int len, input bit patch);
		len_t flen;
		byte_t b;
		flen = len_t'(len);
		for (int i = 0; i < len; i++) begin
			b = frame_buf[i];
			if (patch && len >= min_patch_len && i == len_offset) begin
				b = flen[15:8];
			end else if (patch && len >= min_patch_len && i == len_offset + 1) begin
				b = flen[7:0];
			end
			exp_data.push_back(b);
			exp_first.push_back(i == 0);
			exp_last.push_back(i == len - 1);
		end
	endtask

	task automatic send_frame(input int len, input bit patch);
		@(posedge clk);
		in_frame_valid <= 1'b1; // rising edge stores byte 0
		in_data <= frame_buf[0];
		in_data_latch <= 1'b0;
		for (int i = 1; i < len; i++) begin
			@(posedge clk);
			in_data <= frame_buf[i];
			in_data_latch <= 1'b1;
		end
		@(posedge clk);
		in_frame_valid <= 1'b0;
		in_data_latch <= 1'b0;
		populate_frame_length <= patch;
		@(posedge clk);
		populate_frame_length <= 1'b0;
		repeat (3) @(posedge clk); // room for the patch writes
	endtask

	task automatic compare_frames();
		while (rx_data.size() < exp_data.size()) begin
			@(posedge clk);
		end
		while (exp_data.size() > 0) begin
			check_byte("tx_data", exp_data.pop_front(), rx_data.pop_front());
			check_flag("tx_first", exp_first.pop_front(), rx_first.pop_front());
			check_flag("tx_last", exp_last.pop_front(), rx_last.pop_front());
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	task automatic run_basic();
		@(negedge clk);
		check_flag("tx_valid", 1'b0, tx_valid);
		check_flag("in_data_overflow", 1'b0, in_data_overflow);
		fill_payload(5);
		expect_frame(5, 1'b0);
		send_frame(5, 1'b0);
		compare_frames();
		report_test("single frame");
	endtask

	task automatic check_patch();
		fill_payload(9);
		expect_frame(9, 1'b1);
		send_frame(9, 1'b1);
		fill_payload(3);
		expect_frame(3, 1'b1); // too short, stays unmodified
		send_frame(3, 1'b1);
		compare_frames();
		report_test("length patch");
	endtask

	task automatic stream_with_hold();
		int len;
		hold_random = 1'b1;
		for (int f = 0; f < 3; f++) begin
			len = 1 + ($urandom % 40);
			fill_payload(len);
			expect_frame(len, 1'b0);
			send_frame(len, 1'b0);
		end
		compare_frames();
		hold_random = 1'b0;
		report_test("random hold");
	endtask

	task automatic overflow_drop();
		seen_overflow = 1'b0;
		fill_payload(300);
		send_frame(300, 1'b0);
		repeat (20) @(posedge clk);
		check_flag("in_data_overflow", 1'b1, seen_overflow);
		if (rx_data.size() != 0) begin
			$display("overflowed frame was delivered at %0t", $time);
			test_errors++;
		end
		fill_payload(6);
		expect_frame(6, 1'b0);
		send_frame(6, 1'b0);
		compare_frames();
		report_test("overflow drop");
	endtask

	task automatic held_reader();
		hold_force = 1'b1;
		fill_payload(7);
		expect_frame(7, 1'b0);
		send_frame(7, 1'b0);
		fill_payload(12);
		expect_frame(12, 1'b1);
		send_frame(12, 1'b1);
		// first byte of the first frame sits on the outputs for the whole hold
		repeat (40) begin
			@(negedge clk);
			check_flag("tx_valid", 1'b1, tx_valid);
			check_byte("tx_data", exp_data[0], tx_data);
			check_flag("tx_first", exp_first[0], tx_first);
			check_flag("tx_last", exp_last[0], tx_last);
		end
		hold_force = 1'b0;
		compare_frames();
		report_test("long hold");
	endtask

	initial begin
		int seed_ret;
		seed_ret = $urandom(32'h8919_d0d9);
		rst = 1'b1;
		in_data = '0;
		in_data_latch = 1'b0;
		in_frame_valid = 1'b0;
		populate_frame_length = 1'b0;
		tx_hold = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		run_basic();
		check_patch();
		stream_with_hold();
		overflow_drop();
		held_reader();
		repeat (10) @(posedge clk);
		if (rx_data.size() != 0) begin
			$display("%0d unexpected bytes left at the end", rx_data.size());
			total_errors++;
		end
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
